/* mm_pkg.sv */
package mm_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////////////////////
  localparam int DWIDTH     = 8;   // Matrix element
  localparam int AWIDTH     = 10;  // 1024 words per buffer
  localparam int REG_DWIDTH = 32;
  localparam int REG_AWIDTH = 8;

  // Register map
  typedef enum logic [7:0] {
    REG_CTRL_STATUS = 8'h04,
    REG_MAT_A_ADDR  = 8'h0E,
    REG_MAT_B_ADDR  = 8'h12,
    REG_MAT_C_ADDR  = 8'h16
  } reg_addr_e;

  typedef enum logic [1:0] {
    APB_IDLE,
    APB_W_ENABLE,
    APB_R_ENABLE
  } apb_state_e;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_START,
    ST_RUN,
    ST_DONE
  } mm_state_e;

  // Host port buffer select, anything else hits no buffer
  typedef enum logic [7:0] {
    SEL_A = 8'd0,
    SEL_B = 8'd1,
    SEL_C = 8'd2
  } mem_sel_e;

  typedef struct packed {
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [REG_AWIDTH-1:0] paddr;
    logic [REG_DWIDTH-1:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [AWIDTH-1:0] base_a;
    logic [AWIDTH-1:0] base_b;
    logic [AWIDTH-1:0] base_c;
  } mm_cfg_t;

endpackage

/* bank_ram.sv */
module bank_ram import mm_pkg::*; #(
  parameter int MAT_N = 4,
  localparam int WW = MAT_N * DWIDTH
) (
  input  logic              clk,
  input  logic [AWIDTH-1:0] addr0,
  input  logic [WW-1:0]     d0,
  input  logic              we0,
  output logic [WW-1:0]     q0,
  input  logic [AWIDTH-1:0] addr1,
  input  logic [WW-1:0]     d1,
  input  logic              we1,
  output logic [WW-1:0]     q1
);

  logic [WW-1:0] mem [0:(1<<AWIDTH)-1];

  always_ff @(posedge clk) begin
    if (we0) begin
      mem[addr0] <= d0;
    end
    if (we1) begin
      mem[addr1] <= d1;  // Later write, so port 1 wins on a collision
    end
    q0 <= mem[addr0];    // Old data on read during write
    q1 <= mem[addr1];
  end

endmodule

/* matrix_buffers.sv */
module matrix_buffers import mm_pkg::*; #(
  parameter int MAT_N = 4,
  localparam int WW = MAT_N * DWIDTH
) (
  input  logic              clk,
  // Engine side
  input  logic [AWIDTH-1:0] a_addr,
  input  logic [AWIDTH-1:0] b_addr,
  input  logic [AWIDTH-1:0] c_addr,
  input  logic              c_we,
  input  logic [WW-1:0]     c_wdata,
  output logic [WW-1:0]     a_rdata,
  output logic [WW-1:0]     b_rdata,
  // Host side
  input  mem_sel_e          bram_select,
  input  logic [AWIDTH-1:0] bram_addr_ext,
  input  logic [WW-1:0]     bram_wdata_ext,
  input  logic              bram_we_ext,
  output logic [WW-1:0]     bram_rdata_ext
);

  logic          we_a, we_b, we_c;
  logic [WW-1:0] q_a, q_b, q_c;
  mem_sel_e      sel_q;  // Select aligned with the read data

  assign we_a = bram_we_ext && (bram_select == SEL_A);
  assign we_b = bram_we_ext && (bram_select == SEL_B);
  assign we_c = bram_we_ext && (bram_select == SEL_C);

  always_ff @(posedge clk) begin
    sel_q <= bram_select;
  end

  always_comb begin
    case (sel_q)
      SEL_A:   bram_rdata_ext = q_a;
      SEL_B:   bram_rdata_ext = q_b;
      SEL_C:   bram_rdata_ext = q_c;
      default: bram_rdata_ext = '0;
    endcase
  end

  // A and B are read only from the engine side
  bank_ram #(.MAT_N(MAT_N)) bank_a_inst (
    .clk(clk), .addr0(a_addr), .d0('0), .we0(1'b0), .q0(a_rdata),
    .addr1(bram_addr_ext), .d1(bram_wdata_ext), .we1(we_a), .q1(q_a)
  );

  bank_ram #(.MAT_N(MAT_N)) bank_b_inst (
    .clk(clk), .addr0(b_addr), .d0('0), .we0(1'b0), .q0(b_rdata),
    .addr1(bram_addr_ext), .d1(bram_wdata_ext), .we1(we_b), .q1(q_b)
  );

  bank_ram #(.MAT_N(MAT_N)) bank_c_inst (
    .clk(clk), .addr0(c_addr), .d0(c_wdata), .we0(c_we), .q0(),
    .addr1(bram_addr_ext), .d1(bram_wdata_ext), .we1(we_c), .q1(q_c)
  );

endmodule

/* apb_regs.sv */
module apb_regs import mm_pkg::*; (
  input  logic                  clk,
  input  logic                  PRESETn,
  input  apb_req_t              apb,
  output logic [REG_DWIDTH-1:0] PRDATA,
  output logic                  PREADY,
  output mm_cfg_t               cfg,
  output logic                  start,
  output logic                  clear_done,
  input  logic                  busy,
  input  logic                  done
);

  apb_state_e            state;
  logic [REG_DWIDTH-1:0] sink_q;  // Catches unmapped offsets

  ////////////////////////////////////////////////////////////////////////////
  // APB slave with a single wait state
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!PRESETn) begin
      state      <= APB_IDLE;
      PRDATA     <= '0;
      PREADY     <= 1'b0;
      cfg        <= '0;
      sink_q     <= '0;
      start      <= 1'b0;
      clear_done <= 1'b0;
    end else begin
      PREADY     <= 1'b0;
      start      <= 1'b0;  // Pulses
      clear_done <= 1'b0;
      case (state)
        APB_IDLE: begin
          if (apb.psel && !apb.penable) begin  // Setup phase
            state <= apb.pwrite ? APB_W_ENABLE : APB_R_ENABLE;
          end
        end

        APB_W_ENABLE: begin
          if (apb.psel && apb.penable && apb.pwrite) begin
            case (apb.paddr)
              REG_CTRL_STATUS: begin
                start      <= apb.pwdata[0];
                clear_done <= apb.pwdata[31];
              end
              REG_MAT_A_ADDR: cfg.base_a <= apb.pwdata[AWIDTH-1:0];
              REG_MAT_B_ADDR: cfg.base_b <= apb.pwdata[AWIDTH-1:0];
              REG_MAT_C_ADDR: cfg.base_c <= apb.pwdata[AWIDTH-1:0];
              default:        sink_q     <= apb.pwdata;
            endcase
            PREADY <= 1'b1;
          end
          state <= APB_IDLE;
        end

        APB_R_ENABLE: begin
          if (apb.psel && apb.penable && !apb.pwrite) begin
            case (apb.paddr)
              REG_CTRL_STATUS: PRDATA <= {done, 30'b0, busy};
              REG_MAT_A_ADDR:  PRDATA <= REG_DWIDTH'(cfg.base_a);
              REG_MAT_B_ADDR:  PRDATA <= REG_DWIDTH'(cfg.base_b);
              REG_MAT_C_ADDR:  PRDATA <= REG_DWIDTH'(cfg.base_c);
              default:         PRDATA <= sink_q;
            endcase
            PREADY <= 1'b1;
          end
          state <= APB_IDLE;
        end

        default: state <= APB_IDLE;
      endcase
    end
  end

endmodule

/* mm_ctrl_fsm.sv */
module mm_ctrl_fsm import mm_pkg::*; (
  input  logic clk,
  input  logic PRESETn,
  input  logic start,
  input  logic clear_done,
  input  logic last,            // Final index pair issued
  input  logic c_last_written,  // Final C row in the buffer
  output logic run,
  output logic busy,
  output logic done
);

  mm_state_e state;

  always_ff @(posedge clk) begin
    if (!PRESETn) begin
      state <= ST_IDLE;
      run   <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (start) begin
            state <= ST_START;
          end
        end
        ST_START: begin
          run   <= 1'b1;
          state <= ST_RUN;
        end
        ST_RUN: begin
          if (last) begin
            run <= 1'b0;  // Issue finished, pipeline still draining
          end
          if (c_last_written) begin
            state <= ST_DONE;
          end
        end
        ST_DONE: begin
          if (clear_done) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  assign busy = (state == ST_START) || (state == ST_RUN);
  assign done = (state == ST_DONE);

endmodule

/* index_counter.sv */
module index_counter #(
  parameter int MAT_N = 4,
  localparam int IW = $clog2(MAT_N)
) (
  input  logic          clk,
  input  logic          PRESETn,
  input  logic          run,
  output logic          idx_valid,
  output logic [IW-1:0] row_idx,
  output logic [IW-1:0] col_idx,
  output logic          last
);

  localparam logic [IW-1:0] MAX_IDX = IW'(MAT_N - 1);

  assign idx_valid = run;
  assign last      = run && (row_idx == MAX_IDX) && (col_idx == MAX_IDX);

  // Column runs fastest, both wrap to zero after the final pair
  always_ff @(posedge clk) begin
    if (!PRESETn) begin
      row_idx <= '0;
      col_idx <= '0;
    end else if (run) begin
      if (col_idx == MAX_IDX) begin
        col_idx <= '0;
        row_idx <= (row_idx == MAX_IDX) ? '0 : row_idx + 1'b1;
      end else begin
        col_idx <= col_idx + 1'b1;
      end
    end
  end

endmodule

/* row_dot_unit.sv */
module row_dot_unit import mm_pkg::*; #(
  parameter int MAT_N = 4,
  localparam int IW = $clog2(MAT_N),
  localparam int WW = MAT_N * DWIDTH
) (
  input  logic              clk,
  input  logic              PRESETn,
  input  mm_cfg_t           cfg,
  input  logic              idx_valid,
  input  logic [IW-1:0]     row_idx,
  input  logic [IW-1:0]     col_idx,
  output logic [AWIDTH-1:0] a_addr,
  output logic [AWIDTH-1:0] b_addr,
  output logic [AWIDTH-1:0] c_addr,
  input  logic [WW-1:0]     a_rdata,
  input  logic [WW-1:0]     b_rdata,
  output logic              c_we,
  output logic [WW-1:0]     c_wdata,
  output logic              c_last_written
);

  localparam logic [IW-1:0] MAX_IDX = IW'(MAT_N - 1);

  logic              valid_d1, valid_d2;
  logic [IW-1:0]     row_d1, col_d1;  // Aligned with buffer read data
  logic [IW-1:0]     row_d2, col_d2;  // Aligned with prod_q
  logic [DWIDTH-1:0] dot_sum;
  logic [DWIDTH-1:0] prod_q;
  logic [WW-1:0]     row_q;
  logic [WW-1:0]     row_next;

  // Row r of A and column c of B sit at base + index
  assign a_addr = cfg.base_a + AWIDTH'(row_idx);
  assign b_addr = cfg.base_b + AWIDTH'(col_idx);

  ////////////////////////////////////////////////////////////////////////////
  // Dot product, kept to 8 bits so it wraps modulo 256
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    dot_sum = '0;
    for (int k = 0; k < MAT_N; k++) begin
      dot_sum = dot_sum + a_rdata[k*DWIDTH +: DWIDTH] * b_rdata[k*DWIDTH +: DWIDTH];
    end
  end

  // Newest product dropped into its byte of the C row
  always_comb begin
    row_next = row_q;
    row_next[col_d2*DWIDTH +: DWIDTH] = prod_q;
  end

  always_ff @(posedge clk) begin
    if (!PRESETn) begin
      valid_d1       <= 1'b0;
      valid_d2       <= 1'b0;
      c_we           <= 1'b0;
      c_last_written <= 1'b0;
    end else begin
      valid_d1       <= idx_valid;
      valid_d2       <= valid_d1;
      c_we           <= valid_d2 && (col_d2 == MAX_IDX);  // Row complete
      c_last_written <= valid_d2 && (col_d2 == MAX_IDX) && (row_d2 == MAX_IDX);
    end
  end

  always_ff @(posedge clk) begin
    row_d1 <= row_idx;
    col_d1 <= col_idx;
    row_d2 <= row_d1;
    col_d2 <= col_d1;
    prod_q <= dot_sum;
    if (valid_d2) begin
      row_q   <= row_next;
      c_wdata <= row_next;
      c_addr  <= cfg.base_c + AWIDTH'(row_d2);
    end
  end

endmodule

/* matmul_top.sv */
module matmul_top import mm_pkg::*; #(
  parameter int MAT_N = 4,
  localparam int IW = $clog2(MAT_N),
  localparam int WW = MAT_N * DWIDTH
) (
  input  logic                  clk,
  input  logic                  PRESETn,
  // APB
  input  apb_req_t              apb,
  output logic [REG_DWIDTH-1:0] PRDATA,
  output logic                  PREADY,
  // Host buffer port
  input  mem_sel_e              bram_select,
  input  logic [AWIDTH-1:0]     bram_addr_ext,
  input  logic [WW-1:0]         bram_wdata_ext,
  input  logic                  bram_we_ext,
  output logic [WW-1:0]         bram_rdata_ext
);

  mm_cfg_t           cfg;
  logic              start, clear_done;
  logic              run, busy, done;
  logic              idx_valid, last;
  logic [IW-1:0]     row_idx, col_idx;
  logic [AWIDTH-1:0] a_addr, b_addr, c_addr;
  logic [WW-1:0]     a_rdata, b_rdata;
  logic              c_we;
  logic [WW-1:0]     c_wdata;
  logic              c_last_written;

  ////////////////////////////////////////////////////////////////////////////
  // Register block and run control
  ////////////////////////////////////////////////////////////////////////////
  apb_regs apb_regs_inst (
    .clk        (clk),
    .PRESETn    (PRESETn),
    .apb        (apb),
    .PRDATA     (PRDATA),
    .PREADY     (PREADY),
    .cfg        (cfg),
    .start      (start),
    .clear_done (clear_done),
    .busy       (busy),
    .done       (done)
  );

  mm_ctrl_fsm mm_ctrl_fsm_inst (
    .clk            (clk),
    .PRESETn        (PRESETn),
    .start          (start),
    .clear_done     (clear_done),
    .last           (last),
    .c_last_written (c_last_written),
    .run            (run),
    .busy           (busy),
    .done           (done)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Engine and buffers
  ////////////////////////////////////////////////////////////////////////////
  index_counter #(.MAT_N(MAT_N)) index_counter_inst (
    .clk       (clk),
    .PRESETn   (PRESETn),
    .run       (run),
    .idx_valid (idx_valid),
    .row_idx   (row_idx),
    .col_idx   (col_idx),
    .last      (last)
  );

  row_dot_unit #(.MAT_N(MAT_N)) row_dot_unit_inst (
    .clk            (clk),
    .PRESETn        (PRESETn),
    .cfg            (cfg),
    .idx_valid      (idx_valid),
    .row_idx        (row_idx),
    .col_idx        (col_idx),
    .a_addr         (a_addr),
    .b_addr         (b_addr),
    .c_addr         (c_addr),
    .a_rdata        (a_rdata),
    .b_rdata        (b_rdata),
    .c_we           (c_we),
    .c_wdata        (c_wdata),
    .c_last_written (c_last_written)
  );

  matrix_buffers #(.MAT_N(MAT_N)) matrix_buffers_inst (
    .clk            (clk),
    .a_addr         (a_addr),
    .b_addr         (b_addr),
    .c_addr         (c_addr),
    .c_we           (c_we),
    .c_wdata        (c_wdata),
    .a_rdata        (a_rdata),
    .b_rdata        (b_rdata),
    .bram_select    (bram_select),
    .bram_addr_ext  (bram_addr_ext),
    .bram_wdata_ext (bram_wdata_ext),
    .bram_we_ext    (bram_we_ext),
    .bram_rdata_ext (bram_rdata_ext)
  );

endmodule

/* tb_matmul_top.sv */
module tb_matmul_top import mm_pkg::*; ();

  localparam int MAT_N          = 4;
  localparam int WW             = MAT_N * DWIDTH;
  localparam int RESET_CYCLES   = 5;
  localparam int NUM_TESTS      = 4;
  localparam int TIMEOUT_CYCLES = NUM_TESTS * (MAT_N * MAT_N + 400) + RESET_CYCLES;
  localparam int TDRIVE         = 2;  // Input delay after the rising edge

  typedef enum logic [1:0] {FILL_RANDOM, FILL_IDENT_B, FILL_ALL_FF} fill_e;

  typedef struct packed {
    logic [AWIDTH-1:0] base_a;
    logic [AWIDTH-1:0] base_b;
    logic [AWIDTH-1:0] base_c;
    fill_e             fill;
  } test_row_t;

  logic                  clk;
  logic                  PRESETn;
  apb_req_t              apb;
  logic [REG_DWIDTH-1:0] PRDATA;
  logic                  PREADY;
  mem_sel_e              bram_select;
  logic [AWIDTH-1:0]     bram_addr_ext;
  logic [WW-1:0]         bram_wdata_ext;
  logic                  bram_we_ext;
  logic [WW-1:0]         bram_rdata_ext;

  test_row_t         tests [NUM_TESTS];
  logic [DWIDTH-1:0] a_mat [MAT_N][MAT_N];  // Reference copies of A and B
  logic [DWIDTH-1:0] b_mat [MAT_N][MAT_N];
  logic [31:0]       lcg_state;
  int                cycle_count;
  int                check_count;
  int                error_count;
  int                test_count;

  matmul_top #(.MAT_N(MAT_N)) matmul_top_inst (
    .clk            (clk),
    .PRESETn        (PRESETn),
    .apb            (apb),
    .PRDATA         (PRDATA),
    .PREADY         (PREADY),
    .bram_select    (bram_select),
    .bram_addr_ext  (bram_addr_ext),
    .bram_wdata_ext (bram_wdata_ext),
    .bram_we_ext    (bram_we_ext),
    .bram_rdata_ext (bram_rdata_ext)
  );

  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Run timed out after %0d cycles without finishing", cycle_count);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Data and reference model
  ////////////////////////////////////////////////////////////////////////////
  function automatic logic [DWIDTH-1:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[23:16];
  endfunction

  // Preload pattern mixing every address bit into the upper product bits
  function automatic logic [WW-1:0] fill_word(input logic [AWIDTH-1:0] addr);
    logic [63:0] h;
    h = {54'h0, addr} * 64'h9E37_79B9_7F4A_7C15;
    return h[63 -: WW] ^ WW'(addr);
  endfunction

  function automatic logic [WW-1:0] a_word(input int r);
    logic [WW-1:0] word;
    for (int k = 0; k < MAT_N; k++) begin
      word[k*DWIDTH +: DWIDTH] = a_mat[r][k];  // Row r with element 0 low
    end
    return word;
  endfunction

  function automatic logic [WW-1:0] b_word(input int c);
    logic [WW-1:0] word;
    for (int k = 0; k < MAT_N; k++) begin
      word[k*DWIDTH +: DWIDTH] = b_mat[k][c];  // Column c
    end
    return word;
  endfunction

  function automatic logic [WW-1:0] expected_c_row(input int r);
    logic [WW-1:0] word;
    int            sum;
    for (int j = 0; j < MAT_N; j++) begin
      sum = 0;
      for (int k = 0; k < MAT_N; k++) begin
        sum += a_mat[r][k] * b_mat[k][j];
      end
      word[j*DWIDTH +: DWIDTH] = sum[7:0];  // Wraps modulo 256
    end
    return word;
  endfunction

  task automatic check_value(input string what, input logic [63:0] got,
                             input logic [63:0] exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("Error at %0t: %s: got %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    test_count++;
    if (error_count == errors_before) begin
      $display("Test %0d %s: ok", test_count, name);
    end else begin
      $display("Test %0d %s: %0d errors", test_count, name, error_count - errors_before);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Bus tasks
  ////////////////////////////////////////////////////////////////////////////
  task automatic wait_ready();
    do begin
      @(posedge clk);
      #TDRIVE;
    end while (!PREADY);
  endtask

  task automatic apb_write(input logic [REG_AWIDTH-1:0] addr,
                           input logic [REG_DWIDTH-1:0] data);
    @(posedge clk);
    #TDRIVE;
    apb.psel    = 1'b1;  // Setup phase
    apb.penable = 1'b0;
    apb.pwrite  = 1'b1;
    apb.paddr   = addr;
    apb.pwdata  = data;
    @(posedge clk);
    #TDRIVE;
    apb.penable = 1'b1;
    wait_ready();
    apb.psel    = 1'b0;
    apb.penable = 1'b0;
  endtask

  task automatic apb_read(input logic [REG_AWIDTH-1:0] addr,
                          output logic [REG_DWIDTH-1:0] data);
    @(posedge clk);
    #TDRIVE;
    apb.psel    = 1'b1;
    apb.penable = 1'b0;
    apb.pwrite  = 1'b0;
    apb.paddr   = addr;
    @(posedge clk);
    #TDRIVE;
    apb.penable = 1'b1;
    wait_ready();
    data        = PRDATA;
    apb.psel    = 1'b0;
    apb.penable = 1'b0;
  endtask

  task automatic host_write(input logic [7:0] sel, input logic [AWIDTH-1:0] addr,
                            input logic [WW-1:0] data);
    @(posedge clk);
    #TDRIVE;
    bram_select    = mem_sel_e'(sel);
    bram_addr_ext  = addr;
    bram_wdata_ext = data;
    bram_we_ext    = 1'b1;
    @(posedge clk);
    #TDRIVE;
    bram_we_ext    = 1'b0;
  endtask

  task automatic host_read(input logic [7:0] sel, input logic [AWIDTH-1:0] addr,
                           output logic [WW-1:0] data);
    @(posedge clk);
    #TDRIVE;
    bram_select   = mem_sel_e'(sel);
    bram_addr_ext = addr;
    bram_we_ext   = 1'b0;
    @(posedge clk);
    #TDRIVE;
    data          = bram_rdata_ext;  // One cycle read latency
  endtask

  task automatic start_and_wait();
    logic [REG_DWIDTH-1:0] rd;
    apb_write(REG_CTRL_STATUS, 32'h0000_0001);
    do begin
      apb_read(REG_CTRL_STATUS, rd);
    end while (!rd[31]);
  endtask

  task automatic check_c_rows(input test_row_t row, input string tag);
    logic [WW-1:0] word;
    for (int r = 0; r < MAT_N; r++) begin
      host_read(SEL_C, row.base_c + AWIDTH'(r), word);
      check_value($sformatf("%s C row %0d", tag, r), word, expected_c_row(r));
      if (row.fill == FILL_IDENT_B) begin
        check_value($sformatf("%s C row %0d equals A", tag, r), word, a_word(r));
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // One table row: two runs over the same data
  ////////////////////////////////////////////////////////////////////////////
  task automatic run_table_row(input int t);
    test_row_t             row;
    logic [REG_DWIDTH-1:0] rd;
    logic [WW-1:0]         word;
    logic [AWIDTH-1:0]     addr;
    int                    errors_before;
    row           = tests[t];
    errors_before = error_count;
    for (int i = 0; i < MAT_N; i++) begin
      for (int k = 0; k < MAT_N; k++) begin
        a_mat[i][k] = (row.fill == FILL_ALL_FF) ? 8'hFF : lcg_next();
        case (row.fill)
          FILL_RANDOM:  b_mat[i][k] = lcg_next();
          FILL_IDENT_B: b_mat[i][k] = (i == k) ? 8'd1 : 8'd0;
          default:      b_mat[i][k] = 8'hFF;
        endcase
      end
    end
    apb_write(REG_MAT_A_ADDR, REG_DWIDTH'(row.base_a));
    apb_write(REG_MAT_B_ADDR, REG_DWIDTH'(row.base_b));
    apb_write(REG_MAT_C_ADDR, REG_DWIDTH'(row.base_c));
    for (int r = 0; r < MAT_N; r++) begin
      host_write(SEL_A, row.base_a + AWIDTH'(r), a_word(r));
      host_write(SEL_B, row.base_b + AWIDTH'(r), b_word(r));
    end
    // C rows plus one guard word on each side
    for (int r = -1; r <= MAT_N; r++) begin
      addr = row.base_c + AWIDTH'(r);
      host_write(SEL_C, addr, fill_word(addr));
    end
    start_and_wait();
    check_c_rows(row, $sformatf("test %0d run 1", t));
    addr = row.base_c - 1'b1;
    host_read(SEL_C, addr, word);
    check_value("C guard below", word, fill_word(addr));
    addr = row.base_c + AWIDTH'(MAT_N);
    host_read(SEL_C, addr, word);
    check_value("C guard above", word, fill_word(addr));
    for (int r = 0; r < MAT_N; r++) begin
      host_read(SEL_A, row.base_a + AWIDTH'(r), word);
      check_value($sformatf("A word %0d after run", r), word, a_word(r));
      host_read(SEL_B, row.base_b + AWIDTH'(r), word);
      check_value($sformatf("B word %0d after run", r), word, b_word(r));
    end
    apb_read(REG_CTRL_STATUS, rd);
    check_value("status held at done", rd, 32'h8000_0000);
    apb_write(REG_CTRL_STATUS, 32'h8000_0000);
    apb_read(REG_CTRL_STATUS, rd);
    check_value("status after clear", rd, 32'h0);
    // Second start over a repainted C
    for (int r = 0; r < MAT_N; r++) begin
      addr = row.base_c + AWIDTH'(r);
      host_write(SEL_C, addr, fill_word(addr));
    end
    start_and_wait();
    check_c_rows(row, $sformatf("test %0d run 2", t));
    apb_write(REG_CTRL_STATUS, 32'h8000_0000);
    report_test($sformatf("table row %0d, fill %s", t, row.fill.name()), errors_before);
  endtask

  initial begin
    logic [REG_DWIDTH-1:0] rd;
    logic [WW-1:0]         word;
    int                    errors_before;
    test_row_t             last_row;
    clk            = 1'b0;
    PRESETn        = 1'b0;
    apb            = '0;
    bram_select    = SEL_A;
    bram_addr_ext  = '0;
    bram_wdata_ext = '0;
    bram_we_ext    = 1'b0;
    lcg_state      = 32'h307e;
    cycle_count    = 0;
    check_count    = 0;
    error_count    = 0;
    test_count     = 0;
    tests[0] = '{10'h000, 10'h100, 10'h200, FILL_RANDOM};
    tests[1] = '{10'h040, 10'h080, 10'h3F0, FILL_IDENT_B};
    tests[2] = '{10'h3FC, 10'h001, 10'h010, FILL_ALL_FF};  // Every element wraps to 4
    tests[3] = '{10'h155, 10'h2AA, 10'h0F0, FILL_RANDOM};

    repeat (RESET_CYCLES) @(posedge clk);
    #TDRIVE;
    PRESETn = 1'b1;

    errors_before = error_count;
    apb_read(REG_CTRL_STATUS, rd);
    check_value("reset status", rd, 32'h0);
    apb_read(REG_MAT_A_ADDR, rd);
    check_value("reset base A", rd, 32'h0);
    apb_read(REG_MAT_B_ADDR, rd);
    check_value("reset base B", rd, 32'h0);
    apb_read(REG_MAT_C_ADDR, rd);
    check_value("reset base C", rd, 32'h0);
    report_test("reset values", errors_before);

    errors_before = error_count;
    apb_write(REG_MAT_A_ADDR, 32'hFFFF_F2A5);
    apb_write(REG_MAT_B_ADDR, 32'h1234_5C3A);
    apb_write(REG_MAT_C_ADDR, 32'h0000_07FF);
    apb_read(REG_MAT_A_ADDR, rd);
    check_value("base A readback", rd, 32'hFFFF_F2A5 & ((1 << AWIDTH) - 1));
    apb_read(REG_MAT_B_ADDR, rd);
    check_value("base B readback", rd, 32'h1234_5C3A & ((1 << AWIDTH) - 1));
    apb_read(REG_MAT_C_ADDR, rd);
    check_value("base C readback", rd, 32'h0000_07FF & ((1 << AWIDTH) - 1));
    apb_write(8'h20, 32'hA5C3_1E7F);  // Unmapped offset lands in the sink
    apb_read(8'h3C, rd);
    check_value("sink via 0x3C", rd, 32'hA5C3_1E7F);
    apb_read(8'h00, rd);
    check_value("sink via 0x00", rd, 32'hA5C3_1E7F);
    apb_read(REG_CTRL_STATUS, rd);
    check_value("status after sink write", rd, 32'h0);
    report_test("register access", errors_before);

    for (int t = 0; t < NUM_TESTS; t++) begin
      run_table_row(t);
    end

    // Selects above SEL_C hit no buffer
    errors_before = error_count;
    last_row      = tests[NUM_TESTS-1];
    for (int i = 0; i < 2; i++) begin
      host_read(8'd3 + 8'(i * 252), last_row.base_a, word);
      check_value("unmatched select read", word, '0);
      host_write(8'd3 + 8'(i * 252), last_row.base_a, {WW{1'b1}});
      host_write(8'd3 + 8'(i * 252), last_row.base_b, {WW{1'b1}});
      host_write(8'd3 + 8'(i * 252), last_row.base_c, {WW{1'b1}});
    end
    host_read(SEL_A, last_row.base_a, word);
    check_value("A after unmatched writes", word, a_word(0));
    host_read(SEL_B, last_row.base_b, word);
    check_value("B after unmatched writes", word, b_word(0));
    host_read(SEL_C, last_row.base_c, word);
    check_value("C after unmatched writes", word, expected_c_row(0));
    report_test("unmatched buffer select", errors_before);

    $display("Tests: %0d, checks: %0d, errors: %0d", test_count, check_count, error_count);
    if (error_count == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

/* files.f */
mm_pkg.sv
bank_ram.sv
matrix_buffers.sv
apb_regs.sv
mm_ctrl_fsm.sv
index_counter.sv
row_dot_unit.sv
matmul_top.sv
tb_matmul_top.sv

/* Bender.yml */
package:
  name: matmul_apb

sources:
  - mm_pkg.sv
  - bank_ram.sv
  - matrix_buffers.sv
  - apb_regs.sv
  - mm_ctrl_fsm.sv
  - index_counter.sv
  - row_dot_unit.sv
  - matmul_top.sv
  - target: test
    files:
      - tb_matmul_top.sv
